//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       := tb_ras
FILELIST  := tb.f

SIM  := obj_dir/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'all tests passed'

clean:
	rm -rf obj_dir

//--- dv/tb_ras.sv
/* RAS testbench
   Directed call/return tests against a queue reference stack, with random stalls */
`timescale 1ns/1ps

module tb_ras;

  localparam int RAS_DEPTH   = 4;
  localparam int N_RAND      = 64;
  // Instructions per pass of the four basic tests
  localparam int BASIC_INSTS = 4 + 12 + (2 * RAS_DEPTH + 2) + 7;
  // Three passes of the basic set plus the random stream
  localparam int TOTAL_INSTS = 3 * BASIC_INSTS + N_RAND;
  localparam int TIMEOUT_NS  = (TOTAL_INSTS * 20 + 5) * 8;

  logic                       entry_clk;
  logic                       cpurst_b;
  logic                       flush;
  logic                       icg_force_on;
  logic                       scan_en;
  logic                       in_valid;
  logic                       in_ready;
  logic [ras_pkg::PC_W-1:0]   in_pc;
  logic [ras_pkg::INST_W-1:0] in_inst;
  logic                       out_valid;
  logic                       out_ready;
  logic [ras_pkg::PC_W-1:0]   out_pc;
  logic [1:0]                 out_kind;
  logic [ras_pkg::PC_W-1:0]   out_target;
  logic                       out_target_valid;

  // Reference stack and expected outputs in acceptance order
  logic [ras_pkg::PC_W-1:0] stack_q [$];
  logic [ras_pkg::PC_W-1:0] exp_pc_q [$];
  logic [1:0]               exp_kind_q [$];
  logic [ras_pkg::PC_W-1:0] exp_tgt_q [$];
  logic                     exp_tv_q [$];

  logic                     stall_mode;
  logic                     stall_on;
  logic [31:0]              stall_rng;
  logic [31:0]              stim_rng;
  int                       value_errs;
  int                       other_errs;
  int                       n_checks;
  logic                     hold_chk;
  logic [51:0]              hold_val;
  logic [ras_pkg::PC_W-1:0] e_pc;
  logic [1:0]               e_kind;
  logic [ras_pkg::PC_W-1:0] e_tgt;
  logic                     e_tv;

  ras_top #(
    .RAS_DEPTH (RAS_DEPTH)
  ) dut_i (
    .entry_clk        (entry_clk),
    .cpurst_b         (cpurst_b),
    .flush            (flush),
    .icg_force_on     (icg_force_on),
    .scan_en          (scan_en),
    .in_valid         (in_valid),
    .in_ready         (in_ready),
    .in_pc            (in_pc),
    .in_inst          (in_inst),
    .out_valid        (out_valid),
    .out_ready        (out_ready),
    .out_pc           (out_pc),
    .out_kind         (out_kind),
    .out_target       (out_target),
    .out_target_valid (out_target_valid)
  );

  // 8 ns clock
  initial
  begin
    entry_clk = 1'b0;
  end

  always #4 entry_clk = ~entry_clk;

  //----------------------------------------------------------------------
  // Stimulus helpers
  //----------------------------------------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // J-type word with offset bits scattered per the ISA
  function automatic logic [31:0] encode_jal(input logic [4:0] rd, input logic [20:0] off);
    ras_pkg::inst_u w;
    w.jal.imm20    = off[20];
    w.jal.imm10_1  = off[10:1];
    w.jal.imm11    = off[11];
    w.jal.imm19_12 = off[19:12];
    w.jal.rd       = rd;
    w.jal.opcode   = ras_pkg::OPC_JAL;
    return w;
  endfunction

  function automatic logic [31:0] encode_jalr(input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [11:0] imm);
    ras_pkg::inst_u w;
    w.jalr.imm    = imm;
    w.jalr.rs1    = rs1;
    w.jalr.funct3 = 3'b000;
    w.jalr.rd     = rd;
    w.jalr.opcode = ras_pkg::OPC_JALR;
    return w;
  endfunction

  // Reference model using the link hints of the ISA manual
  task automatic predict(input logic [23:0] pc, input logic [31:0] inst);
    logic [6:0]  opc;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic        is_jr;
    logic        rd_link;
    logic        rs1_link;
    logic [20:0] off;
    logic [1:0]  kind;
    logic [23:0] tgt;
    logic        tv;
    opc      = inst[6:0];
    rd       = inst[11:7];
    rs1      = inst[19:15];
    is_jr    = (opc == ras_pkg::OPC_JALR) && (inst[14:12] == 3'b000);
    rd_link  = (rd == ras_pkg::LINK_X1) || (rd == ras_pkg::LINK_X5);
    rs1_link = (rs1 == ras_pkg::LINK_X1) || (rs1 == ras_pkg::LINK_X5);
    off      = {inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    kind     = ras_pkg::KIND_NONE;
    tgt      = '0;
    tv       = 1'b0;
    if (((opc == ras_pkg::OPC_JAL) || is_jr) && rd_link)
    begin
      kind = ras_pkg::KIND_CALL;
      tv   = (opc == ras_pkg::OPC_JAL);
      tgt  = pc + {{3{off[20]}}, off};
      stack_q.push_back(pc + 24'd4);
      // Oldest link lost on overflow
      if (stack_q.size() > RAS_DEPTH)
      begin
        stack_q.delete(0);
      end
    end
    else if (is_jr && (rd == 5'd0) && rs1_link)
    begin
      kind = ras_pkg::KIND_RET;
      if (stack_q.size() != 0)
      begin
        tv  = 1'b1;
        tgt = stack_q.pop_back();
      end
    end
    exp_pc_q.push_back(pc);
    exp_kind_q.push_back(kind);
    exp_tgt_q.push_back(tgt);
    exp_tv_q.push_back(tv);
  endtask

  // Called at posedge+1 and returns at posedge+1 after the transfer edge
  task automatic send_inst(input logic [23:0] pc, input logic [31:0] inst);
    logic accepted;
    predict(pc, inst);
    in_valid = 1'b1;
    in_pc    = pc;
    in_inst  = inst;
    accepted = 1'b0;
    while (!accepted)
    begin
      @(negedge entry_clk);
      accepted = in_ready;
      @(posedge entry_clk);
    end
    #1;
    in_valid = 1'b0;
  endtask

  // Waits until every sent instruction has come out
  task automatic drain_pipe;
    do
    begin
      @(posedge entry_clk);
      #1;
    end
    while (exp_pc_q.size() != 0);
  endtask

  task automatic flush_stack;
    drain_pipe();
    flush = 1'b1;
    @(posedge entry_clk);
    #1;
    flush = 1'b0;
    stack_q.delete();
  endtask

  //----------------------------------------------------------------------
  // Directed tests
  //----------------------------------------------------------------------
  task automatic call_and_return;
    flush_stack();
    send_inst(24'h001000, encode_jal(ras_pkg::LINK_X1, 21'h000400));
    send_inst(24'h001400, encode_jalr(5'd0, ras_pkg::LINK_X1, 12'h000));
    // jalr call with target unknown at decode
    send_inst(24'h002000, encode_jalr(ras_pkg::LINK_X1, 5'd6, 12'h010));
    send_inst(24'h003000, encode_jalr(5'd0, ras_pkg::LINK_X1, 12'h000));
  endtask

  task automatic nested_calls(input logic [4:0] link);
    int i;
    flush_stack();
    for (i = 1; i <= 3; i++)
    begin
      send_inst(24'(i * 24'h100), encode_jal(link, 21'h1FFF00));
    end
    for (i = 0; i < 3; i++)
    begin
      send_inst(24'h008000 + 24'(i * 4), encode_jalr(5'd0, link, 12'h000));
    end
  endtask

  task automatic stack_overflow;
    int i;
    flush_stack();
    for (i = 0; i <= RAS_DEPTH; i++)
    begin
      send_inst(24'h004000 + 24'(i * 24'h40), encode_jal(ras_pkg::LINK_X5, 21'h000800));
    end
    // Last return finds the stack empty
    for (i = 0; i <= RAS_DEPTH; i++)
    begin
      send_inst(24'h005000 + 24'(i * 4), encode_jalr(5'd0, ras_pkg::LINK_X1, 12'h000));
    end
  endtask

  task automatic other_and_flush;
    flush_stack();
    send_inst(24'h006000, 32'h00100093);
    send_inst(24'h006004, encode_jal(5'd0, 21'h000020));
    send_inst(24'h006008, encode_jalr(5'd0, 5'd2, 12'h000));
    send_inst(24'h00600C, encode_jalr(5'd0, ras_pkg::LINK_X1, 12'h000));
    send_inst(24'h006100, encode_jal(ras_pkg::LINK_X1, 21'h000100));
    send_inst(24'h006200, encode_jal(ras_pkg::LINK_X1, 21'h000100));
    flush_stack();
    send_inst(24'h006300, encode_jalr(5'd0, ras_pkg::LINK_X1, 12'h000));
  endtask

  task automatic run_basic_set;
    call_and_return();
    nested_calls(ras_pkg::LINK_X1);
    nested_calls(ras_pkg::LINK_X5);
    stack_overflow();
    other_and_flush();
    drain_pipe();
  endtask

  // Mixed stream under out_ready stalls from the stall driver
  task automatic random_backpressure;
    logic [31:0] r;
    logic [4:0]  link;
    logic [31:0] inst;
    int          i;
    flush_stack();
    stall_mode = 1'b1;
    for (i = 0; i < N_RAND; i++)
    begin
      stim_rng = xorshift32(stim_rng);
      r        = stim_rng;
      link     = r[2] ? ras_pkg::LINK_X5 : ras_pkg::LINK_X1;
      case (r[1:0])
        2'd0:    inst = encode_jal(link, {r[22:3], 1'b0});
        2'd1:    inst = encode_jalr(link, 5'd10, r[31:20]);
        2'd2:    inst = encode_jalr(5'd0, link, 12'h000);
        default: inst = r[3] ? 32'h00000013 : encode_jal(5'd0, {r[22:3], 1'b0});
      endcase
      send_inst({r[31:10], 2'b00}, inst);
    end
    drain_pipe();
    stall_mode = 1'b0;
  endtask

  task automatic gated_clock_repeat;
    icg_force_on = 1'b1;
    run_basic_set();
    icg_force_on = 1'b0;
    scan_en      = 1'b1;
    run_basic_set();
    scan_en      = 1'b0;
  endtask

  //----------------------------------------------------------------------
  // Output monitor sampling mid-cycle where all signals are settled
  //----------------------------------------------------------------------
  always @(negedge entry_clk)
  begin
    if (cpurst_b)
    begin
      if (hold_chk)
      begin
        n_checks++;
        assert (hold_val == {out_valid, out_pc, out_kind, out_target, out_target_valid})
        else
        begin
          value_errs++;
          $display("FAILED %s hold: got %h expected %h",
                   "{out_valid,out_pc,out_kind,out_target,out_target_valid}",
                   {out_valid, out_pc, out_kind, out_target, out_target_valid}, hold_val);
        end
      end
      if (out_valid && out_ready)
      begin
        assert (exp_pc_q.size() != 0)
        else
        begin
          other_errs++;
          $display("Output at pc %h came out with no instruction outstanding", out_pc);
        end
        if (exp_pc_q.size() != 0)
        begin
          e_pc   = exp_pc_q.pop_front();
          e_kind = exp_kind_q.pop_front();
          e_tgt  = exp_tgt_q.pop_front();
          e_tv   = exp_tv_q.pop_front();
          n_checks++;
          assert (out_pc == e_pc)
          else
          begin
            value_errs++;
            $display("FAILED out_pc: got %h expected %h", out_pc, e_pc);
          end
          assert (out_kind == e_kind)
          else
          begin
            value_errs++;
            $display("FAILED out_kind: got %h expected %h", out_kind, e_kind);
          end
          assert (out_target_valid == e_tv)
          else
          begin
            value_errs++;
            $display("FAILED out_target_valid: got %h expected %h", out_target_valid, e_tv);
          end
          // Target only meaningful when flagged valid
          assert (!e_tv || (out_target == e_tgt))
          else
          begin
            value_errs++;
            $display("FAILED out_target: got %h expected %h", out_target, e_tgt);
          end
        end
      end
      hold_chk = out_valid && !out_ready;
      hold_val = {out_valid, out_pc, out_kind, out_target, out_target_valid};
    end
  end

  // Stall driver with random out_ready only in stall mode
  always @(posedge entry_clk)
  begin
    // Mode taken at the edge, a cycle after the test changes it
    stall_on = stall_mode;
    #1;
    if (stall_on)
    begin
      stall_rng = xorshift32(stall_rng);
      out_ready = stall_rng[4];
    end
    else
    begin
      out_ready = 1'b1;
    end
  end

  //----------------------------------------------------------------------
  // Main sequence and watchdog
  //----------------------------------------------------------------------
  initial
  begin
    cpurst_b     = 1'b0;
    flush        = 1'b0;
    icg_force_on = 1'b0;
    scan_en      = 1'b0;
    in_valid     = 1'b0;
    in_pc        = '0;
    in_inst      = '0;
    out_ready    = 1'b1;
    stall_mode   = 1'b0;
    stall_rng    = 32'd44955;
    stim_rng     = xorshift32(32'd44955);
    value_errs   = 0;
    other_errs   = 0;
    n_checks     = 0;
    hold_chk     = 1'b0;
    hold_val     = '0;
    repeat (5) @(posedge entry_clk);
    #1;
    cpurst_b = 1'b1;
    assert (!out_valid && in_ready)
    else
    begin
      other_errs++;
      $display("Pipeline not idle after reset release");
    end
    run_basic_set();
    random_backpressure();
    gated_clock_repeat();
    drain_pipe();
    $display("checks: %0d, value errors: %0d, other errors: %0d",
             n_checks, value_errs, other_errs);
    if ((value_errs + other_errs) == 0)
    begin
      $display("all tests passed");
    end
    else
    begin
      $display("tests failed");
    end
    $finish;
  end

  initial
  begin
    #(TIMEOUT_NS);
    $display("Timeout, pipeline stopped delivering outputs");
    $display("checks: %0d, value errors: %0d, other errors: %0d",
             n_checks, value_errs, other_errs);
    $display("tests failed");
    $finish;
  end

endmodule

//--- tb.f
verilog/ras_pkg.sv
verilog/clk_gate.sv
verilog/ras_entry.sv
verilog/ras_decode.sv
verilog/ras_stack.sv
verilog/ras_top.sv
dv/tb_ras.sv

//--- verilog/clk_gate.sv
/* Integrated clock gate
   Low-transparent latch on the enable, ANDed with the clock */
`timescale 1ns/1ps

module clk_gate (
  input  logic clk_in,
  input  logic local_en,
  input  logic force_on,
  input  logic scan_en,
  output logic clk_out
);

  // Latched enable, settles while the clock is low
  logic en_lat;

  // Any of the three sources opens the gate
  always_latch
  begin
    if (!clk_in)
    begin
      en_lat <= local_en | force_on | scan_en;
    end
  end

  // Enable frozen during the high phase, so no glitch on clk_out
  assign clk_out = clk_in & en_lat;

endmodule

//--- verilog/ras_decode.sv
/* RAS decode stage
   Sorts words into call, return or other; registers link and jal target */
`timescale 1ns/1ps

module ras_decode (
  input  logic                       entry_clk,
  input  logic                       cpurst_b,
  // Fetch channel
  input  logic                       in_valid,
  output logic                       in_ready,
  input  logic [ras_pkg::PC_W-1:0]   in_pc,
  input  logic [ras_pkg::INST_W-1:0] in_inst,
  // Channel to the stack stage
  output logic                       dec_valid,
  input  logic                       dec_ready,
  output logic [ras_pkg::PC_W-1:0]   dec_pc,
  output logic [1:0]                 dec_kind,
  output logic [ras_pkg::PC_W-1:0]   dec_link,
  output logic [ras_pkg::PC_W-1:0]   dec_target,
  output logic                       dec_target_valid
);

  localparam logic [ras_pkg::PC_W-1:0] INST_BYTES = ras_pkg::PC_W'(4);

  ras_pkg::inst_u            inst;
  logic                      is_jal;
  logic                      is_jalr;
  logic                      rd_link;
  logic                      rs1_link;
  logic                      is_call;
  logic                      is_ret;
  logic [1:0]                kind;
  logic [ras_pkg::PC_W-1:0]  jal_off;
  logic                      in_fire;

  //----------------------------------------------------------------------
  // Classification
  //----------------------------------------------------------------------
  assign inst = in_inst;

  // Opcode sits in the same bits for both views
  assign is_jal  = (inst.jal.opcode == ras_pkg::OPC_JAL);
  assign is_jalr = (inst.jalr.opcode == ras_pkg::OPC_JALR) && (inst.jalr.funct3 == 3'b000);

  // Link register hints, x1 or x5
  assign rd_link  = (inst.jal.rd == ras_pkg::LINK_X1) || (inst.jal.rd == ras_pkg::LINK_X5);
  assign rs1_link = (inst.jalr.rs1 == ras_pkg::LINK_X1) || (inst.jalr.rs1 == ras_pkg::LINK_X5);

  // rd link wins, so a jalr ra,ra is a plain call
  assign is_call = (is_jal || is_jalr) && rd_link;
  assign is_ret  = is_jalr && (inst.jalr.rd == 5'd0) && rs1_link;

  assign kind = is_call ? ras_pkg::KIND_CALL :
                is_ret  ? ras_pkg::KIND_RET  : ras_pkg::KIND_NONE;

  // J-type offset, scrambled bits back in order and sign extended
  assign jal_off = {{(ras_pkg::PC_W - 20){inst.jal.imm20}}, inst.jal.imm19_12,
                    inst.jal.imm11, inst.jal.imm10_1, 1'b0};

  //----------------------------------------------------------------------
  // Output register and handshake
  //----------------------------------------------------------------------
  // Accept when empty or draining this cycle
  assign in_ready = !dec_valid || dec_ready;
  assign in_fire  = in_valid && in_ready;

  always_ff @(posedge entry_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      dec_valid <= 1'b0;
    end
    else if (in_fire)
    begin
      dec_valid <= 1'b1;
    end
    else if (dec_ready)
    begin
      dec_valid <= 1'b0;
    end
  end

  // Payload, only a jal call has a target known here
  always_ff @(posedge entry_clk)
  begin
    if (in_fire)
    begin
      dec_pc           <= in_pc;
      dec_kind         <= kind;
      dec_link         <= in_pc + INST_BYTES;
      dec_target       <= in_pc + jal_off;
      dec_target_valid <= is_jal && is_call;
    end
  end

  // Stalled output must hold until the stack stage takes it
  a_dec_hold : assert property (@(posedge entry_clk) disable iff (!cpurst_b)
    dec_valid && !dec_ready |=> dec_valid && $stable(dec_pc) && $stable(dec_kind)
      && $stable(dec_link) && $stable(dec_target) && $stable(dec_target_valid));

endmodule

//--- verilog/ras_entry.sv
/* RAS stack slot
   One return address on its own gated clock, written on update only */
`timescale 1ns/1ps

module ras_entry (
  input  logic                     entry_clk,
  input  logic                     cpurst_b,
  input  logic                     icg_force_on,
  input  logic                     scan_en,
  input  logic                     entry_upd,
  input  logic [ras_pkg::PC_W-1:0] upd_pc,
  output logic [ras_pkg::PC_W-1:0] entry_pc
);

  logic gated_clk;

  //----------------------------------------------------------------------
  // Clock gate
  //----------------------------------------------------------------------
  // Slot clock only ticks on a write, unless forced or in scan
  clk_gate u_icg (
    .clk_in   (entry_clk),
    .local_en (entry_upd),
    .force_on (icg_force_on),
    .scan_en  (scan_en),
    .clk_out  (gated_clk)
  );

  //----------------------------------------------------------------------
  // Stored return address
  //----------------------------------------------------------------------
  // Update still qualified, the clock may run free when forced
  always_ff @(posedge gated_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      entry_pc <= '0;
    end
    else if (entry_upd)
    begin
      entry_pc <= upd_pc;
    end
  end

endmodule

//--- verilog/ras_pkg.sv
/* RAS shared definitions
   Widths, jal/jalr opcodes, link registers, kind codes and instruction views */
package ras_pkg;

  // Datapath widths
  localparam int PC_W   = 24;
  localparam int INST_W = 32;

  // Major opcodes
  localparam logic [6:0] OPC_JAL  = 7'b1101111;
  localparam logic [6:0] OPC_JALR = 7'b1100111;

  // Link registers per the RISC-V hint table (ra, t0)
  localparam logic [4:0] LINK_X1 = 5'd1;
  localparam logic [4:0] LINK_X5 = 5'd5;

  // Instruction class on the stage ports
  localparam logic [1:0] KIND_NONE = 2'd0;
  localparam logic [1:0] KIND_CALL = 2'd1;
  localparam logic [1:0] KIND_RET  = 2'd2;

  // One instruction word, read as J-type or as I-type jalr
  typedef union packed {
    struct packed {
      logic       imm20;
      logic [9:0] imm10_1;
      logic       imm11;
      logic [7:0] imm19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
    } jal;
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } jalr;
  } inst_u;

endpackage

//--- verilog/ras_stack.sv
/* RAS stack stage
   Circular return stack with saturating count; registers the prediction */
`timescale 1ns/1ps

module ras_stack #(
  parameter int RAS_DEPTH = 4
) (
  input  logic                     entry_clk,
  input  logic                     cpurst_b,
  input  logic                     flush,
  input  logic                     icg_force_on,
  input  logic                     scan_en,
  // Channel from decode
  input  logic                     dec_valid,
  output logic                     dec_ready,
  input  logic [ras_pkg::PC_W-1:0] dec_pc,
  input  logic [1:0]               dec_kind,
  input  logic [ras_pkg::PC_W-1:0] dec_link,
  input  logic [ras_pkg::PC_W-1:0] dec_target,
  input  logic                     dec_target_valid,
  // Prediction channel
  output logic                     out_valid,
  input  logic                     out_ready,
  output logic [ras_pkg::PC_W-1:0] out_pc,
  output logic [1:0]               out_kind,
  output logic [ras_pkg::PC_W-1:0] out_target,
  output logic                     out_target_valid
);

  localparam int PTR_W = $clog2(RAS_DEPTH);
  localparam int CNT_W = $clog2(RAS_DEPTH + 1);
  localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(RAS_DEPTH);

  logic                     dec_fire;
  logic [PTR_W-1:0]         top_ptr;
  logic [PTR_W-1:0]         push_ptr;
  logic [CNT_W-1:0]         count;
  logic [CNT_W-1:0]         count_eff;
  logic [CNT_W-1:0]         count_nxt;
  logic                     push;
  logic                     pop;
  logic [RAS_DEPTH-1:0]     slot_wr;
  logic [ras_pkg::PC_W-1:0] slot_pc [RAS_DEPTH];

  assign dec_ready = !out_valid || out_ready;
  assign dec_fire  = dec_valid && dec_ready;

  //----------------------------------------------------------------------
  // Pointer and occupancy
  //----------------------------------------------------------------------
  // Flush empties first, then this edge's instruction sees an empty stack
  assign count_eff = flush ? '0 : count;

  assign push     = dec_fire && (dec_kind == ras_pkg::KIND_CALL);
  assign pop      = dec_fire && (dec_kind == ras_pkg::KIND_RET) && (count_eff != '0);
  // Wraps naturally, depth is a power of two
  assign push_ptr = top_ptr + 1'b1;

  always_comb
  begin
    count_nxt = count_eff;
    if (push && (count_eff != CNT_FULL))
    begin
      count_nxt = count_eff + 1'b1;
    end
    else if (pop)
    begin
      count_nxt = count_eff - 1'b1;
    end
  end

  // On overflow the push lands on the oldest slot
  always_ff @(posedge entry_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      top_ptr <= '0;
      count   <= '0;
    end
    else
    begin
      count <= count_nxt;
      if (push)
      begin
        top_ptr <= push_ptr;
      end
      else if (pop)
      begin
        top_ptr <= top_ptr - 1'b1;
      end
    end
  end

  //----------------------------------------------------------------------
  // Slots
  //----------------------------------------------------------------------
  assign slot_wr = push ? (RAS_DEPTH'(1) << push_ptr) : '0;

  for (genvar i = 0; i < RAS_DEPTH; i++)
  begin : g_slot
    ras_entry u_entry (
      .entry_clk    (entry_clk),
      .cpurst_b     (cpurst_b),
      .icg_force_on (icg_force_on),
      .scan_en      (scan_en),
      .entry_upd    (slot_wr[i]),
      .upd_pc       (dec_link),
      .entry_pc     (slot_pc[i])
    );
  end

  //----------------------------------------------------------------------
  // Prediction register
  //----------------------------------------------------------------------
  always_ff @(posedge entry_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      out_valid <= 1'b0;
    end
    else if (dec_fire)
    begin
      out_valid <= 1'b1;
    end
    else if (out_ready)
    begin
      out_valid <= 1'b0;
    end
  end

  // Returns read the top slot, everything else keeps the decode target
  always_ff @(posedge entry_clk)
  begin
    if (dec_fire)
    begin
      out_pc   <= dec_pc;
      out_kind <= dec_kind;
      if (dec_kind == ras_pkg::KIND_RET)
      begin
        out_target       <= slot_pc[top_ptr];
        out_target_valid <= (count_eff != '0);
      end
      else
      begin
        out_target       <= dec_target;
        out_target_valid <= dec_target_valid;
      end
    end
  end

  // At most one slot clocked per cycle
  a_wr_onehot : assert property (@(posedge entry_clk) disable iff (!cpurst_b)
    $onehot0(slot_wr));

  // Occupancy saturates at the depth
  a_cnt_max : assert property (@(posedge entry_clk) disable iff (!cpurst_b)
    count <= CNT_FULL);

endmodule

//--- verilog/ras_top.sv
/* RAS top level
   Decode stage feeding the stack stage, two-cycle prediction pipeline */
`timescale 1ns/1ps

module ras_top #(
  parameter int RAS_DEPTH = 4
) (
  input  logic                       entry_clk,
  input  logic                       cpurst_b,
  input  logic                       flush,
  input  logic                       icg_force_on,
  input  logic                       scan_en,
  input  logic                       in_valid,
  output logic                       in_ready,
  input  logic [ras_pkg::PC_W-1:0]   in_pc,
  input  logic [ras_pkg::INST_W-1:0] in_inst,
  output logic                       out_valid,
  input  logic                       out_ready,
  output logic [ras_pkg::PC_W-1:0]   out_pc,
  output logic [1:0]                 out_kind,
  output logic [ras_pkg::PC_W-1:0]   out_target,
  output logic                       out_target_valid
);

  // Decode to stack channel
  logic                     dec_valid;
  logic                     dec_ready;
  logic [ras_pkg::PC_W-1:0] dec_pc;
  logic [1:0]               dec_kind;
  logic [ras_pkg::PC_W-1:0] dec_link;
  logic [ras_pkg::PC_W-1:0] dec_target;
  logic                     dec_target_valid;

  ras_decode u_decode (
    .entry_clk        (entry_clk),
    .cpurst_b         (cpurst_b),
    .in_valid         (in_valid),
    .in_ready         (in_ready),
    .in_pc            (in_pc),
    .in_inst          (in_inst),
    .dec_valid        (dec_valid),
    .dec_ready        (dec_ready),
    .dec_pc           (dec_pc),
    .dec_kind         (dec_kind),
    .dec_link         (dec_link),
    .dec_target       (dec_target),
    .dec_target_valid (dec_target_valid)
  );

  // Stack depth set here only
  ras_stack #(
    .RAS_DEPTH (RAS_DEPTH)
  ) u_stack (
    .entry_clk        (entry_clk),
    .cpurst_b         (cpurst_b),
    .flush            (flush),
    .icg_force_on     (icg_force_on),
    .scan_en          (scan_en),
    .dec_valid        (dec_valid),
    .dec_ready        (dec_ready),
    .dec_pc           (dec_pc),
    .dec_kind         (dec_kind),
    .dec_link         (dec_link),
    .dec_target       (dec_target),
    .dec_target_valid (dec_target_valid),
    .out_valid        (out_valid),
    .out_ready        (out_ready),
    .out_pc           (out_pc),
    .out_kind         (out_kind),
    .out_target       (out_target),
    .out_target_valid (out_target_valid)
  );

endmodule
